// File: hdl/huff_pkg.sv
// shared types for the JPEG entropy coder; values assumed in -2047..2047 (size up to 11)
// FIFO_DEPTH must stay a power of two, pointers wrap naturally
package huff_pkg;

    localparam int FIFO_DEPTH = 4;                // input token buffer
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int PIPE_DEPTH = 4;                // symbol issue to out_valid
    localparam int DRAIN_W    = $clog2(PIPE_DEPTH + 1);

    localparam logic [7:0] EOB_SYMBOL = 8'h00;    // end of block
    localparam logic [7:0] F0_SYMBOL  = 8'hf0;    // 16 zeros

    typedef logic [15:0] token_t;      // run-length prepared input word
    typedef logic [11:0] value_t;      // signed coefficient
    typedef logic [3:0]  size_t;       // size category 0..11
    typedef logic [3:0]  run_t;        // zeros before an AC value
    typedef logic [1:0]  f0_cnt_t;     // pending 16-zero groups
    typedef logic [10:0] literal_t;    // literal, right aligned
    typedef logic [8:0]  tab_addr_t;   // {color, symbol}
    typedef logic [19:0] tab_entry_t;  // {len (0 = 16), code}
    typedef logic [26:0] out_bits_t;   // msb aligned output word
    typedef logic [4:0]  out_len_t;    // bits used in out_bits_t

    typedef logic [FIFO_AW-1:0] fifo_ptr_t;
    typedef logic [FIFO_AW:0]   fifo_cnt_t;   // 0..FIFO_DEPTH
    typedef logic [DRAIN_W-1:0] drain_cnt_t;  // 0..PIPE_DEPTH

    typedef enum logic [1:0] {
        SYM_DC,
        SYM_AC,
        SYM_EOB,
        SYM_F0
    } sym_kind_e;

    typedef enum logic [1:0] {
        ST_IDLE,   // between frames
        ST_RUN,    // decoding tokens
        ST_F0,     // expanding a long zero run
        ST_DRAIN   // last word issued, waiting for pipe to empty
    } seq_state_e;

endpackage

// File: hdl/sym_if.sv
// one symbol per cycle from the sequencer to the magnitude coder, no back-pressure
`timescale 1ns/1ps
interface sym_if;

    logic                valid;   // symbol strobe
    huff_pkg::sym_kind_e kind;    // DC / AC / EOB / F0
    logic                color;   // 0 luma, 1 chroma
    huff_pkg::run_t      run;     // zeros before an AC value
    huff_pkg::value_t    value;   // signed value, zero for EOB/F0

    modport src (
        output valid,
        output kind,
        output color,
        output run,
        output value
    );

    modport dst (
        input valid,
        input kind,
        input color,
        input run,
        input value
    );

endinterface

// File: hdl/token_fifo.sv
// small token buffer, in_ready registered so it drops only when FIFO_DEPTH words wait
// head is shown combinationally and leaves on pop in the same cycle
`timescale 1ns/1ps
module token_fifo (
    input  logic             xclk,
    input  logic             rst,
    input  logic             in_valid,
    input  huff_pkg::token_t in_token,
    input  logic             pop,
    output logic             in_ready,
    output logic             pop_valid,
    output huff_pkg::token_t pop_token
);

    huff_pkg::token_t    mem [huff_pkg::FIFO_DEPTH];  // token storage
    huff_pkg::fifo_ptr_t wr_ptr;
    huff_pkg::fifo_ptr_t rd_ptr;
    huff_pkg::fifo_cnt_t count;
    huff_pkg::fifo_cnt_t count_nxt;
    logic                push;

    assign push      = in_valid && in_ready;   // handshake
    assign pop_valid = (count != '0);
    assign pop_token = mem[rd_ptr];            // head word

    always_comb begin
        count_nxt = count;
        if (push && !pop) count_nxt = count + 1'b1;
        else if (pop && !push) count_nxt = count - 1'b1;
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b0;  // low one cycle after reset
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count    <= count_nxt;
            in_ready <= (count_nxt != huff_pkg::fifo_cnt_t'(huff_pkg::FIFO_DEPTH));
        end
    end

    always_ff @(posedge xclk) begin
        if (push) mem[wr_ptr] <= in_token;
    end

    // sequencer must only pop a word that is there
    a_pop_not_empty: assert property (@(posedge xclk) disable iff (rst) pop |-> pop_valid);

endmodule

// File: hdl/token_sequencer.sv
// decodes tokens into symbols, expands zero runs into F0 codes, times flush
// a new frame is not read until flush of the previous last block has gone out
`timescale 1ns/1ps
module token_sequencer (
    input  logic               xclk,
    input  logic               rst,
    input  logic               pop_valid,
    input  huff_pkg::token_t   pop_token,
    input  huff_pkg::f0_cnt_t  f0_pending,
    output logic               pop,
    output logic               f0_load,
    output huff_pkg::f0_cnt_t  f0_init,
    output logic               f0_take,
    output logic               flush,
    output logic               last_block,
    sym_if.src                 sym
);

    huff_pkg::seq_state_e state;
    huff_pkg::seq_state_e state_nxt;
    huff_pkg::drain_cnt_t drain_cnt;   // cycles since final issue
    huff_pkg::run_t       run_q;       // low run held for next AC
    huff_pkg::sym_kind_e  kind_nxt;
    logic                 color_q;     // from last DC token
    logic                 issue;
    logic                 is_dc;
    logic                 is_ac;
    logic                 is_rll;
    logic                 is_eob;
    logic                 last_word;
    logic                 drain_done;

    assign is_dc  = pop_token[15] && pop_token[14];
    assign is_ac  = pop_token[15] && !pop_token[14];
    assign is_rll = !pop_token[15] && !pop_token[12];
    assign is_eob = !pop_token[15] && pop_token[12];
    assign last_word = (is_ac && pop_token[12]) || is_eob;  // closes a block

    assign pop = pop_valid && (state == huff_pkg::ST_IDLE || state == huff_pkg::ST_RUN);
    assign f0_load = pop && is_rll && (pop_token[5:4] != 2'd0);
    assign f0_init = pop_token[5:4];               // groups of 16 zeros
    assign f0_take = (state == huff_pkg::ST_F0);   // one F0 per cycle
    assign drain_done = (drain_cnt == huff_pkg::drain_cnt_t'(huff_pkg::PIPE_DEPTH));

    always_comb begin
        issue    = 1'b0;
        kind_nxt = huff_pkg::SYM_EOB;
        if (f0_take) begin
            issue    = 1'b1;
            kind_nxt = huff_pkg::SYM_F0;
        end else if (pop && !is_rll) begin   // zero run issues nothing itself
            issue = 1'b1;
            if (is_dc) kind_nxt = huff_pkg::SYM_DC;
            else if (is_ac) kind_nxt = huff_pkg::SYM_AC;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            huff_pkg::ST_IDLE, huff_pkg::ST_RUN: begin
                if (pop) begin
                    if (f0_load) state_nxt = huff_pkg::ST_F0;
                    else if (last_block && last_word) state_nxt = huff_pkg::ST_DRAIN;
                    else state_nxt = huff_pkg::ST_RUN;
                end
            end
            huff_pkg::ST_F0: if (f0_pending == 2'd1) state_nxt = huff_pkg::ST_RUN;
            huff_pkg::ST_DRAIN: if (drain_done) state_nxt = huff_pkg::ST_IDLE;
            default: state_nxt = huff_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            state      <= huff_pkg::ST_IDLE;
            drain_cnt  <= '0;
            run_q      <= '0;
            color_q    <= 1'b0;
            flush      <= 1'b0;
            last_block <= 1'b0;
            sym.valid  <= 1'b0;
        end else begin
            state     <= state_nxt;
            drain_cnt <= (state == huff_pkg::ST_DRAIN) ? drain_cnt + 1'b1 : '0;
            flush     <= (state == huff_pkg::ST_DRAIN) && drain_done;  // after final out_valid
            sym.valid <= issue;
            if (pop) run_q <= is_rll ? pop_token[3:0] : 4'd0;  // any other token clears it
            if (pop && is_dc) color_q <= pop_token[13];
            if (pop && is_dc && pop_token[12]) last_block <= 1'b1;  // last block begins
            else if (flush) last_block <= 1'b0;
        end
    end

    // symbol payload, meaningful only with sym.valid
    always_ff @(posedge xclk) begin
        sym.kind  <= kind_nxt;
        sym.color <= (pop && is_dc) ? pop_token[13] : color_q;
        sym.run   <= (pop && is_ac) ? run_q : 4'd0;
        sym.value <= (pop && (is_dc || is_ac)) ? pop_token[11:0] : 12'd0;
    end

    // F0 codes only while the counter still holds groups
    a_f0_pending: assert property (@(posedge xclk) disable iff (rst)
        f0_take |-> (f0_pending != 2'd0));

endmodule

// File: hdl/zero_run_counter.sv
// counts the 16-zero groups of one zero run down to zero, one per take
`timescale 1ns/1ps
module zero_run_counter (
    input  logic              xclk,
    input  logic              rst,
    input  logic              f0_load,
    input  huff_pkg::f0_cnt_t f0_init,
    input  logic              f0_take,
    output huff_pkg::f0_cnt_t f0_pending
);

    huff_pkg::f0_cnt_t cnt;

    assign f0_pending = cnt;

    always_ff @(posedge xclk) begin
        if (rst) begin
            cnt <= '0;
        end else if (f0_load) begin
            cnt <= f0_init;           // bits 5:4 of the run
        end else if (f0_take && cnt != '0) begin
            cnt <= cnt - 1'b1;        // one F0 code sent
        end
    end

    // a load lands only outside an F0 expansion
    a_load_take: assert property (@(posedge xclk) disable iff (rst)
        !(f0_load && f0_take));

endmodule

// File: hdl/magnitude_coder.sv
// size category and literal per JPEG rules, table address as {color, symbol}
// literal follows rd_en by 2 cycles so it meets the table output
`timescale 1ns/1ps
module magnitude_coder (
    input  logic                xclk,
    input  logic                rst,
    sym_if.dst                  sym,
    output logic                rd_en,
    output huff_pkg::tab_addr_t rd_addr,
    output logic                lit_valid,
    output huff_pkg::literal_t  lit_bits,
    output huff_pkg::size_t     lit_len
);

    huff_pkg::value_t   mag;          // absolute value
    huff_pkg::value_t   adj;          // value, or value - 1 when negative
    huff_pkg::size_t    size;
    huff_pkg::literal_t lit_mask;
    logic [7:0]         sym_byte;
    logic               lit_v   [2];  // delay line, valid
    huff_pkg::literal_t lit_b   [3];  // delay line, bits
    huff_pkg::size_t    lit_l   [3];  // delay line, length

    assign mag = sym.value[11] ? 12'(-sym.value) : sym.value;
    assign adj = sym.value[11] ? sym.value - 12'd1 : sym.value;

    always_comb begin
        size = '0;
        for (int i = 0; i < 11; i++) begin
            if (mag[i]) size = huff_pkg::size_t'(i + 1);   // highest set bit
        end
    end

    assign lit_mask = huff_pkg::literal_t'((12'd1 << size) - 12'd1);

    always_comb begin
        case (sym.kind)
            huff_pkg::SYM_DC:  sym_byte = {size, 4'hf};
            huff_pkg::SYM_AC:  sym_byte = {sym.run, size};
            huff_pkg::SYM_EOB: sym_byte = huff_pkg::EOB_SYMBOL;
            default:           sym_byte = huff_pkg::F0_SYMBOL;
        endcase
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            rd_en    <= 1'b0;
            lit_v[0] <= 1'b0;
            lit_v[1] <= 1'b0;
        end else begin
            rd_en    <= sym.valid;
            lit_v[0] <= rd_en;
            lit_v[1] <= lit_v[0];
        end
    end

    always_ff @(posedge xclk) begin
        rd_addr  <= {sym.color, sym_byte};       // chroma in upper half
        lit_b[0] <= adj[10:0] & lit_mask;        // keep low size bits
        lit_l[0] <= (sym.kind == huff_pkg::SYM_EOB || sym.kind == huff_pkg::SYM_F0) ?
                    4'd0 : size;                 // no literal for EOB/F0
        lit_b[1] <= lit_b[0];
        lit_l[1] <= lit_l[0];
        lit_b[2] <= lit_b[1];
        lit_l[2] <= lit_l[1];
    end

    assign lit_valid = lit_v[1];
    assign lit_bits  = lit_b[2];
    assign lit_len   = lit_l[2];

endmodule

// File: hdl/code_table.sv
// Huffman code memory, luma in 0..255, chroma in 256..511
// write only while the encoder is idle, reads take 2 cycles (read reg + output reg)
`timescale 1ns/1ps
module code_table (
    input  logic                 xclk,
    input  logic                 tab_we,
    input  huff_pkg::tab_addr_t  tab_addr,
    input  huff_pkg::tab_entry_t tab_data,
    input  logic                 rd_en,
    input  huff_pkg::tab_addr_t  rd_addr,
    output huff_pkg::tab_entry_t rd_entry
);

    huff_pkg::tab_entry_t mem [512];   // block memory
    huff_pkg::tab_entry_t rd_q;        // first read stage
    logic                 rd_en_q;     // output register enable

    always_ff @(posedge xclk) begin
        if (tab_we) mem[tab_addr] <= tab_data;
    end

    always_ff @(posedge xclk) begin
        if (rd_en) rd_q <= mem[rd_addr];
        rd_en_q <= rd_en;
    end

    always_ff @(posedge xclk) begin
        if (rd_en_q) rd_entry <= rd_q;   // holds between reads
    end

endmodule

// File: hdl/code_merger.sv
// joins code and literal into one msb aligned word, code length 0 decodes as 16
// code plus literal must fit 27 bits, true for JPEG tables
`timescale 1ns/1ps
module code_merger (
    input  logic                 xclk,
    input  logic                 rst,
    input  logic                 lit_valid,
    input  huff_pkg::tab_entry_t rd_entry,
    input  huff_pkg::literal_t   lit_bits,
    input  huff_pkg::size_t      lit_len,
    output logic                 out_valid,
    output huff_pkg::out_bits_t  out_bits,
    output huff_pkg::out_len_t   out_len
);

    huff_pkg::out_len_t  code_len;    // 1..16
    huff_pkg::out_len_t  total_len;
    huff_pkg::out_bits_t code_al;     // code at the top
    huff_pkg::out_bits_t lit_al;      // literal right below

    assign code_len  = (rd_entry[19:16] == 4'd0) ? 5'd16 : {1'b0, rd_entry[19:16]};
    assign total_len = code_len + {1'b0, lit_len};

    assign code_al = {rd_entry[15:0], 11'd0} << (5'd16 - code_len);
    assign lit_al  = {16'd0, lit_bits} << (5'd27 - total_len);

    always_ff @(posedge xclk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= lit_valid;
        end
    end

    always_ff @(posedge xclk) begin
        out_bits <= code_al | lit_al;   // unused low bits are zero
        out_len  <= total_len;
    end

    // table entry and literal meet here; together they must fit the word
    a_len_fits: assert property (@(posedge xclk) disable iff (rst)
        lit_valid |-> (total_len <= 5'd27));

endmodule

// File: hdl/huffman_encoder.sv
// JPEG Huffman stage, 16-bit tokens in, msb aligned codes with length out
// no output ready; write tables only while idle; byte packing and stuffing are downstream
`timescale 1ns/1ps
module huffman_encoder (
    input  logic                 xclk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  huff_pkg::token_t     in_token,
    input  logic                 tab_we,
    input  huff_pkg::tab_addr_t  tab_addr,
    input  huff_pkg::tab_entry_t tab_data,
    output logic                 in_ready,
    output logic                 out_valid,
    output huff_pkg::out_bits_t  out_bits,
    output huff_pkg::out_len_t   out_len,
    output logic                 flush,
    output logic                 last_block
);

    logic                 pop_valid;
    huff_pkg::token_t     pop_token;
    logic                 pop;
    logic                 f0_load;
    huff_pkg::f0_cnt_t    f0_init;
    logic                 f0_take;
    huff_pkg::f0_cnt_t    f0_pending;
    logic                 rd_en;
    huff_pkg::tab_addr_t  rd_addr;
    huff_pkg::tab_entry_t rd_entry;
    logic                 lit_valid;
    huff_pkg::literal_t   lit_bits;
    huff_pkg::size_t      lit_len;

    sym_if sym ();   // sequencer to coder

    token_fifo u_fifo (
        .xclk      (xclk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_token  (in_token),
        .pop       (pop),
        .in_ready  (in_ready),
        .pop_valid (pop_valid),
        .pop_token (pop_token)
    );

    token_sequencer u_seq (
        .xclk       (xclk),
        .rst        (rst),
        .pop_valid  (pop_valid),
        .pop_token  (pop_token),
        .f0_pending (f0_pending),
        .pop        (pop),
        .f0_load    (f0_load),
        .f0_init    (f0_init),
        .f0_take    (f0_take),
        .flush      (flush),
        .last_block (last_block),
        .sym        (sym.src)
    );

    zero_run_counter u_f0 (
        .xclk       (xclk),
        .rst        (rst),
        .f0_load    (f0_load),
        .f0_init    (f0_init),
        .f0_take    (f0_take),
        .f0_pending (f0_pending)
    );

    magnitude_coder u_mag (
        .xclk      (xclk),
        .rst       (rst),
        .sym       (sym.dst),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .lit_valid (lit_valid),
        .lit_bits  (lit_bits),
        .lit_len   (lit_len)
    );

    code_table u_tab (
        .xclk     (xclk),
        .tab_we   (tab_we),
        .tab_addr (tab_addr),
        .tab_data (tab_data),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_entry (rd_entry)
    );

    code_merger u_merge (
        .xclk      (xclk),
        .rst       (rst),
        .lit_valid (lit_valid),
        .rd_entry  (rd_entry),
        .lit_bits  (lit_bits),
        .lit_len   (lit_len),
        .out_valid (out_valid),
        .out_bits  (out_bits),
        .out_len   (out_len)
    );

endmodule

// File: tests/huff_model.svh
// reference rules for the Huffman stage, included inside the testbench module
// table contents here are the ones written into the DUT after reset
localparam logic [15:0] CODE_MIX = 16'h9e37;

huff_pkg::out_bits_t exp_bits_q [$];   // expected words, oldest first
huff_pkg::out_len_t  exp_len_q  [$];

function automatic int code_length(input int addr);
    return 1 + (addr % 16);   // 1..16
endfunction

function automatic huff_pkg::tab_entry_t table_entry(input int addr);
    int          len;
    logic [15:0] code;
    len  = code_length(addr);
    code = 16'(addr) * CODE_MIX;
    code = code ^ (code >> 8) ^ 16'h5a5a;          // folds the color bit down to bit 0
    code = code & 16'((32'd1 << len) - 32'd1);     // keep len bits
    return {4'(len % 16), code};                   // length 16 stored as 0
endfunction

function automatic int size_category(input int v);
    int mag;
    int s;
    mag = (v < 0) ? -v : v;
    s   = 0;
    while (mag > 0) begin
        s++;
        mag = mag >> 1;
    end
    return s;
endfunction

function automatic int literal_of(input int v, input int s);
    return ((v < 0) ? v - 1 : v) & ((1 << s) - 1);   // low s bits only
endfunction

// table code on top, literal bits right below it
task automatic expect_word(input logic chroma, input logic [7:0] sym, input int v, input int s);
    int                   addr;
    int                   clen;
    huff_pkg::tab_entry_t ent;
    logic [31:0]          word;
    addr = {chroma, sym};       // chroma selects upper half
    clen = code_length(addr);
    ent  = table_entry(addr);
    word = (32'(ent[15:0]) << (27 - clen)) | (32'(literal_of(v, s)) << (27 - clen - s));
    exp_bits_q.push_back(word[26:0]);
    exp_len_q.push_back(5'(clen + s));
endtask

// File: tests/tb_huffman_encoder.sv
// directed tests for the JPEG Huffman stage, inputs driven on the falling edge
// outputs checked on the falling edge against words built from the reference rules
`timescale 1ns/1ps
module tb_huffman_encoder;

    localparam int NUM_TOKENS      = 36;                      // over all tests
    localparam int WATCHDOG_CYCLES = NUM_TOKENS * 20 + 2000;
    localparam int WAIT_LIMIT      = 200;                     // cycles per wait

    logic                 xclk;
    logic                 rst;
    logic                 in_valid;
    huff_pkg::token_t     in_token;
    logic                 tab_we;
    huff_pkg::tab_addr_t  tab_addr;
    huff_pkg::tab_entry_t tab_data;
    logic                 in_ready;
    logic                 out_valid;
    huff_pkg::out_bits_t  out_bits;
    huff_pkg::out_len_t   out_len;
    logic                 flush;
    logic                 last_block;

    int                   flush_count = 0;
    logic                 prev_valid  = 1'b0;  // out_valid one cycle back
    logic                 stall_seen  = 1'b0;  // in_ready low while offering
    huff_pkg::out_bits_t  head_bits;
    huff_pkg::out_len_t   head_len;

    `include "huff_model.svh"

    huffman_encoder dut (
        .xclk       (xclk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_token   (in_token),
        .tab_we     (tab_we),
        .tab_addr   (tab_addr),
        .tab_data   (tab_data),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_bits   (out_bits),
        .out_len    (out_len),
        .flush      (flush),
        .last_block (last_block)
    );

    always #4 xclk = ~xclk;   // 8 ns period

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic int rand_value();
        return int'($urandom % 32'd4095) - 2047;   // -2047..2047
    endfunction

    // entered and left on a falling edge
    task automatic send_token(input huff_pkg::token_t tok);
        in_valid = 1'b1;
        in_token = tok;
        while (!in_ready) begin
            stall_seen = 1'b1;
            @(negedge xclk);
        end
        @(negedge xclk);      // taken on the rising edge just passed
        in_valid = 1'b0;
    endtask

    task automatic send_dc(input logic chroma, input logic last, input int v);
        expect_word(chroma, {4'(size_category(v)), 4'hf}, v, size_category(v));
        send_token({2'b11, chroma, last, 12'(v)});
    endtask

    task automatic send_ac(input logic chroma, input int run, input logic last, input int v);
        expect_word(chroma, {4'(run), 4'(size_category(v))}, v, size_category(v));
        send_token({3'b100, last, 12'(v)});   // color bit ignored on AC
    endtask

    task automatic send_run(input logic chroma, input int zeros);
        repeat (zeros / 16) expect_word(chroma, 8'hf0, 0, 0);   // one F0 per 16 zeros
        send_token({10'd0, 6'(zeros)});
    endtask

    task automatic send_eob(input logic chroma);
        expect_word(chroma, 8'h00, 0, 0);
        send_token(16'h1000);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_bits_q.size() != 0) begin
            @(negedge xclk);
            waited++;
            assert (waited < WAIT_LIMIT) else stop_on_error("expected output words never came out");
        end
        repeat (2) @(negedge xclk);
    endtask

    // compare every output word with the oldest expected one
    always @(negedge xclk) begin
        if (!rst) begin
            if (out_valid) begin
                assert (exp_bits_q.size() != 0)
                    else stop_on_error("output word appeared when none was expected");
                head_bits = exp_bits_q.pop_front();
                head_len  = exp_len_q.pop_front();
                assert (out_bits == head_bits) else stop_on_error(
                    $sformatf("MISMATCH out_bits got %h expected %h", out_bits, head_bits));
                assert (out_len == head_len) else stop_on_error(
                    $sformatf("MISMATCH out_len got %h expected %h", out_len, head_len));
            end
            if (flush) begin
                flush_count++;
                assert (prev_valid) else stop_on_error("flush did not follow the final output word");
                assert (exp_bits_q.size() == 0)
                    else stop_on_error("flush came while words were still expected");
            end
            prev_valid = out_valid;
        end
    end

    task automatic load_tables();
        for (int a = 0; a < 512; a++) begin
            tab_we   = 1'b1;
            tab_addr = huff_pkg::tab_addr_t'(a);
            tab_data = table_entry(a);
            @(negedge xclk);
            assert (!out_valid && !flush && !last_block)
                else stop_on_error("out_valid, flush or last_block went high during table load");
        end
        tab_we = 1'b0;
    endtask

    task automatic luma_block_test();
        send_dc(1'b0, 1'b0, rand_value());
        send_ac(1'b0, 0, 1'b0, -1);
        send_ac(1'b0, 0, 1'b0, -2047);   // longest literal
        send_ac(1'b0, 0, 1'b0, 2047);
        send_ac(1'b0, 0, 1'b0, -300);
        repeat (2) send_ac(1'b0, 0, 1'b0, rand_value());
        send_eob(1'b0);
        wait_drain();
    endtask

    task automatic chroma_block_test();
        send_dc(1'b1, 1'b0, rand_value());   // color comes from here only
        repeat (4) send_ac(1'b1, 0, 1'b0, rand_value());
        send_eob(1'b1);
        wait_drain();
    endtask

    task automatic zero_run_test();
        send_dc(1'b0, 1'b0, rand_value());
        send_run(1'b0, 37);                  // two F0, run 5 left
        send_ac(1'b0, 5, 1'b0, rand_value());
        send_run(1'b0, 15);                  // no F0
        send_ac(1'b0, 15, 1'b0, rand_value());
        send_eob(1'b0);
        wait_drain();
    endtask

    task automatic backpressure_test();
        stall_seen = 1'b0;
        send_dc(1'b1, 1'b0, rand_value());
        send_run(1'b1, 51);                  // three F0, fifo fills meanwhile
        send_ac(1'b1, 3, 1'b0, rand_value());
        repeat (7) send_ac(1'b1, 0, 1'b0, rand_value());
        send_eob(1'b1);
        wait_drain();
        assert (stall_seen) else stop_on_error("in_ready never dropped under back-pressure");
    endtask

    task automatic last_block_test();
        int waited;
        waited = 0;
        assert (!last_block) else stop_on_error("last_block high before the last block");
        send_dc(1'b0, 1'b1, rand_value());
        repeat (3) send_ac(1'b0, 0, 1'b0, rand_value());
        send_ac(1'b0, 0, 1'b1, rand_value());
        assert (last_block) else stop_on_error("last_block did not rise after the last DC token");
        while (!flush) begin
            @(negedge xclk);
            waited++;
            assert (waited < WAIT_LIMIT) else stop_on_error("flush never came after the last block");
        end
        repeat (8) @(negedge xclk);          // room for a stray word or pulse
        assert (flush_count == 1) else stop_on_error(
            $sformatf("MISMATCH flush_count got %h expected %h", flush_count, 1));
        assert (!last_block) else stop_on_error("last_block still high after flush");
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge xclk);
        stop_on_error("watchdog expired before the tests finished");
    end

    initial begin
        void'($urandom(32'h34c57520));       // one seed for the whole run
        xclk     = 1'b0;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_token = '0;
        tab_we   = 1'b0;
        tab_addr = '0;
        tab_data = '0;
        repeat (5) @(negedge xclk);
        rst = 1'b0;
        load_tables();
        luma_block_test();
        chroma_block_test();
        zero_run_test();
        backpressure_test();
        last_block_test();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: project.f
+incdir+tests
hdl/huff_pkg.sv
hdl/sym_if.sv
hdl/token_fifo.sv
hdl/token_sequencer.sv
hdl/zero_run_counter.sv
hdl/magnitude_coder.sv
hdl/code_table.sv
hdl/code_merger.sv
hdl/huffman_encoder.sv
tests/tb_huffman_encoder.sv

// File: Bender.yml
package:
  name: huffman_encoder

sources:
  - files:
      - hdl/huff_pkg.sv
      - hdl/sym_if.sv
      - hdl/token_fifo.sv
      - hdl/token_sequencer.sv
      - hdl/zero_run_counter.sv
      - hdl/magnitude_coder.sv
      - hdl/code_table.sv
      - hdl/code_merger.sv
      - hdl/huffman_encoder.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_huffman_encoder.sv
